// ==== flist.f ====
+incdir+common
common/mem_pkg.sv
common/ram_port_if.sv
design/bram.sv
axi_lite_mem_ctrl/axi_lite_mem_ctrl.sv
design/mem_subsys_top.sv
test/tb_mem_subsys.sv

// ==== test/tb_mem_subsys.sv ====
// self-checking testbench for the scratchpad subsystem; run with flist.f, top module tb_mem_subsys
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int WORDS = 1 << `MEM_DEPTH_BITS;   // shadow size matches the RAM
    localparam int TMO   = 200;                    // cycle limit for any single wait

    logic                    clk;
    logic                    rst_n;
    logic                    awvalid, wvalid, bready, arvalid, rready;
    logic                    awready, wready, bvalid, arready, rvalid;
    logic [`MEM_ADDR_W-1:0]  awaddr, araddr;
    logic [2:0]              awprot, arprot;
    logic [`MEM_DATA_W-1:0]  wdata, rdata;
    logic [`MEM_STRB_W-1:0]  wstrb;
    axi_resp_t               bresp, rresp;

    logic [`MEM_DATA_W-1:0]  shadow [0:WORDS-1];   // expected RAM contents
    logic                    last_grant_rd;        // latest address handshake was a read

    mem_subsys_top dut (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awprot (awprot),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arprot (arprot),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                          // 8 ns period

    // ##############################
    // reference model
    // ##############################
    function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[`MEM_ADDR_W-1:`MEM_DEPTH_BITS+2] == '0;   // nothing above the word index
    endfunction

    // strobed bytes come from the new word, the rest stay
    function automatic logic [`MEM_DATA_W-1:0] merge_bytes(input logic [`MEM_DATA_W-1:0] old_w,
            input logic [`MEM_DATA_W-1:0] new_w, input logic [`MEM_STRB_W-1:0] strb);
        logic [`MEM_DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // {resp, data} a read of addr should return right now
    function automatic logic [`MEM_DATA_W+1:0] expect_read(input logic [`MEM_ADDR_W-1:0] addr);
        if (!in_range(addr)) begin
            return {SLVERR, {`MEM_DATA_W{1'b0}}};      // errors read as zero
        end
        return {OKAY, shadow[addr[`MEM_DEPTH_BITS+1:2]]};
    endfunction

    // mostly a handful of words so reads land on recent writes
    function automatic logic [`MEM_ADDR_W-1:0] pick_addr();
        logic [`MEM_ADDR_W-1:0] a;
        a = ($urandom % 8) * 4 + ($urandom % 4);   // low bits are don't care
        if (($urandom % 6) == 0) begin
            a = a | (32'h1 << $urandom_range(`MEM_ADDR_W-1, `MEM_DEPTH_BITS+2));
        end
        return a;
    endfunction

    // ##############################
    // checking helpers
    // ##############################
    task automatic check_val(input logic [`MEM_DATA_W-1:0] actual,
            input logic [`MEM_DATA_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_failed(input string what);
        $display("The DUT did not raise %s within %0d cycles.", what, TMO);
        $display("Test failures found");
        $fatal(1, "stopped on timeout");
    endtask

    // ##############################
    // bus tasks
    // ##############################
    task automatic axi_write(input logic [`MEM_ADDR_W-1:0] addr,
            input logic [`MEM_DATA_W-1:0] data, input logic [`MEM_STRB_W-1:0] strb, input int hold);
        int        n;
        axi_resp_t exp_resp;
        axi_resp_t held_resp;
        @(negedge clk);
        awaddr  = addr;
        awprot  = 3'b011;                          // ignored by the slave
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(posedge clk);
        while (!awready) begin
            if (n >= TMO) begin
                wait_failed("awready");
            end else begin
                n++;
                @(posedge clk);
            end
        end
        check_val(wready, 1'b1, "wready with awready");
        last_grant_rd = 1'b0;
        // handshake on this edge, so the model changes in bus order
        exp_resp = in_range(addr) ? OKAY : SLVERR;
        if (in_range(addr)) begin
            shadow[addr[`MEM_DEPTH_BITS+1:2]] = merge_bytes(shadow[addr[`MEM_DEPTH_BITS+1:2]],
                                                            data, strb);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;                            // response is held off at first
        n = 0;
        @(posedge clk);
        while (!bvalid) begin
            if (n >= TMO) begin
                wait_failed("bvalid");
            end else begin
                n++;
                @(posedge clk);
            end
        end
        check_val(bresp, exp_resp, $sformatf("bresp for %h", addr));
        held_resp = bresp;
        repeat (hold) begin
            @(posedge clk);
            check_val(bvalid, 1'b1, "bvalid under back-pressure");
            check_val(bresp, held_resp, "bresp under back-pressure");
            check_val(arready, 1'b0, "arready while B pending");
        end
        @(negedge clk);
        bready = 1'b1;
        @(posedge clk);                            // B handshake
        check_val(bvalid, 1'b1, "bvalid at B handshake");
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`MEM_ADDR_W-1:0] addr, input int hold);
        int                     n;
        logic [`MEM_DATA_W+1:0] exp;
        logic [`MEM_DATA_W-1:0] held_data;
        axi_resp_t              held_resp;
        @(negedge clk);
        araddr  = addr;
        arprot  = 3'b101;
        arvalid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!arready) begin
            if (n >= TMO) begin
                wait_failed("arready");
            end else begin
                n++;
                @(posedge clk);
            end
        end
        last_grant_rd = 1'b1;
        exp = expect_read(addr);                   // state as of the AR handshake
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b0;
        n = 0;
        @(posedge clk);
        while (!rvalid) begin
            if (n >= TMO) begin
                wait_failed("rvalid");
            end else begin
                n++;
                @(posedge clk);
            end
        end
        check_val(rresp, exp[`MEM_DATA_W+1:`MEM_DATA_W], $sformatf("rresp for %h", addr));
        check_val(rdata, exp[`MEM_DATA_W-1:0], $sformatf("rdata for %h", addr));
        held_data = rdata;
        held_resp = rresp;
        repeat (hold) begin
            @(posedge clk);
            check_val(rvalid, 1'b1, "rvalid under back-pressure");
            check_val(rdata, held_data, "rdata under back-pressure");
            check_val(rresp, held_resp, "rresp under back-pressure");
            check_val(awready, 1'b0, "awready while R pending");
        end
        @(negedge clk);
        rready = 1'b1;
        @(posedge clk);                            // R handshake
        check_val(rvalid, 1'b1, "rvalid at R handshake");
        @(negedge clk);
        rready = 1'b0;
    endtask

    // a full write and a read start in the same cycle, grant order decides the model
    task automatic concurrent_pairs(input int count, input int hold_max);
        logic [`MEM_ADDR_W-1:0] wa, ra;
        logic [`MEM_DATA_W-1:0] wd;
        logic [`MEM_STRB_W-1:0] ws;
        int                     wh, rh;
        logic                   second_rd;
        for (int i = 0; i < count; i++) begin
            if (i % 2 == 1) begin
                axi_write(pick_addr(), $urandom, $urandom, 0);   // read wins the next tie
            end
            wa = pick_addr();
            ra = pick_addr();
            wd = $urandom;
            ws = $urandom;
            wh = $urandom_range(hold_max, 0);
            rh = $urandom_range(hold_max, 0);
            second_rd = last_grant_rd;             // side that went last waits in a tie
            fork
                axi_write(wa, wd, ws, wh);
                axi_read(ra, rh);
            join
            check_val(last_grant_rd, second_rd, "side granted second in a tie");
        end
    endtask

    // ##############################
    // test sequence
    // ##############################
    initial begin
        logic [`MEM_ADDR_W-1:0] oor_addr [3];
        void'($urandom(32'h65d8_0dcd));
        rst_n = 1'b0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr = '0;
        araddr = '0;
        awprot = '0;
        arprot = '0;
        wdata  = '0;
        wstrb  = '0;
        last_grant_rd = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;                        // RAM starts cleared
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // full-word writes, then read them all back
        for (int i = 0; i < 8; i++) begin
            axi_write(i * 32'h204, $urandom, 4'hf, 0);
        end
        axi_write(32'h0000_0ffc, $urandom, 4'hf, 0);    // last word
        for (int i = 0; i < 8; i++) begin
            axi_read(i * 32'h204 + i % 4, 0);
        end
        axi_read(32'h0000_0ffc, 0);

        // every strobe pattern over one known word
        axi_write(32'h0000_0300, 32'h1122_3344, 4'hf, 0);
        for (int s = 0; s < 16; s++) begin
            axi_write(32'h0000_0300, $urandom, s[3:0], 0);
            axi_read(32'h0000_0300, 0);
        end

        // out of range, the alias word must not move
        oor_addr[0] = 32'h0000_1004;
        oor_addr[1] = 32'h0004_0104;
        oor_addr[2] = 32'h8000_0ffc;
        for (int i = 0; i < 3; i++) begin
            axi_write(oor_addr[i] & 32'hfff, $urandom, 4'hf, 0);
            axi_write(oor_addr[i], 32'hdead_beef, 4'hf, 0);
            axi_read(oor_addr[i], 0);
            axi_read(oor_addr[i] & 32'hfff, 0);
        end

        concurrent_pairs(4, 12);                   // long back-pressure
        concurrent_pairs(40, 3);                   // random mixed traffic

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
// scratchpad subsystem top: plain AXI4-Lite slave ports in front of a 4 KiB block RAM
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_subsys_top (
    input  wire                      clk,
    input  wire                      rst_n,

    // AW
    input  wire                      awvalid,
    output logic                     awready,
    input  wire  [`MEM_ADDR_W-1:0]   awaddr,
    input  wire  [2:0]               awprot,
    // W
    input  wire                      wvalid,
    output logic                     wready,
    input  wire  [`MEM_DATA_W-1:0]   wdata,
    input  wire  [`MEM_STRB_W-1:0]   wstrb,
    // B
    output logic                     bvalid,
    input  wire                      bready,
    output mem_pkg::axi_resp_t       bresp,
    // AR
    input  wire                      arvalid,
    output logic                     arready,
    input  wire  [`MEM_ADDR_W-1:0]   araddr,
    input  wire  [2:0]               arprot,
    // R
    output logic                     rvalid,
    input  wire                      rready,
    output logic [`MEM_DATA_W-1:0]   rdata,
    output mem_pkg::axi_resp_t       rresp
);

    // controller to RAM link, sized to the word address
    ram_port_if #(.AW(`MEM_DEPTH_BITS)) ram_bus ();

    // ##############################
    // bus slave
    // ##############################
    axi_lite_mem_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .ram     (ram_bus.ctrl)
    );

    // ##############################
    // storage
    // ##############################
    bram #(
        .WIDTH (`MEM_DEPTH_BITS)
    ) u_ram (
        .clk (clk),
        .ram (ram_bus.ram)
    );

endmodule

`default_nettype wire

// ==== axi_lite_mem_ctrl/axi_lite_mem_ctrl.sv ====
// AXI4-Lite slave FSM that turns single-beat bus transfers into block RAM accesses
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module axi_lite_mem_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,

    // write address channel
    input  wire                      awvalid,
    output logic                     awready,
    input  wire  [`MEM_ADDR_W-1:0]   awaddr,
    input  wire  [2:0]               awprot,     // accepted, no protection checks

    // write data channel
    input  wire                      wvalid,
    output logic                     wready,
    input  wire  [`MEM_DATA_W-1:0]   wdata,
    input  wire  [`MEM_STRB_W-1:0]   wstrb,

    // write response channel
    output logic                     bvalid,
    input  wire                      bready,
    output mem_pkg::axi_resp_t       bresp,

    // read address channel
    input  wire                      arvalid,
    output logic                     arready,
    input  wire  [`MEM_ADDR_W-1:0]   araddr,
    input  wire  [2:0]               arprot,     // accepted, no protection checks

    // read data channel
    output logic                     rvalid,
    input  wire                      rready,
    output logic [`MEM_DATA_W-1:0]   rdata,
    output mem_pkg::axi_resp_t       rresp,

    ram_port_if.ctrl                 ram
);

    import mem_pkg::*;

    localparam int WLO = 2;                        // byte offset bits dropped
    localparam int WHI = `MEM_DEPTH_BITS + WLO;    // first bit above the word range

    ctrl_state_t            state;
    logic                   last_rd;   // last grant went to a read
    axi_resp_t              bresp_q;
    axi_resp_t              rresp_q;
    logic [`MEM_DATA_W-1:0] rdata_q;

    logic                   idle;
    logic                   wr_pend;   // AW and W both waiting
    logic                   wr_take;   // write accepted this cycle
    logic                   rd_take;   // read accepted this cycle
    logic                   aw_ok;
    logic                   ar_ok;

    // ##############################
    // arbitration
    // ##############################
    assign idle    = (state == IDLE);
    assign wr_pend = awvalid & wvalid;     // half a write never blocks a read

    // on a tie the side that did not go last wins
    assign wr_take = idle & wr_pend & (~arvalid | last_rd);
    assign rd_take = idle & arvalid & (~wr_pend | ~last_rd);

    // anything set above the word index is outside the RAM
    assign aw_ok = ~|awaddr[`MEM_ADDR_W-1:WHI];
    assign ar_ok = ~|araddr[`MEM_ADDR_W-1:WHI];

    // ##############################
    // bus handshake outputs
    // ##############################
    assign awready = wr_take;              // AW and W complete together
    assign wready  = wr_take;
    assign arready = rd_take;              // high for the accept cycle only
    assign bvalid  = (state == WRITE_RESP);
    assign rvalid  = (state == READ_RESP);
    assign bresp   = bresp_q;
    assign rresp   = rresp_q;
    assign rdata   = rdata_q;

    // ##############################
    // RAM port
    // ##############################
    // address is presented in the accept cycle, both for writes and reads
    assign ram.addr  = wr_take ? awaddr[WHI-1:WLO] : araddr[WHI-1:WLO];
    assign ram.wdata = wdata;
    assign ram.wmask = wstrb;
    assign ram.wr    = wr_take & aw_ok;     // out of range leaves memory alone

    // ##############################
    // FSM
    // ##############################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            last_rd <= 1'b0;                // first tie goes to the read
            bresp_q <= OKAY;
            rresp_q <= OKAY;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_take) begin
                        state   <= WRITE_RESP;        // bvalid next cycle
                        last_rd <= 1'b0;
                        bresp_q <= aw_ok ? OKAY : SLVERR;
                    end else if (rd_take) begin
                        state   <= READ_RAM;          // RAM output valid next cycle
                        last_rd <= 1'b1;
                        rresp_q <= ar_ok ? OKAY : SLVERR;
                    end
                end
                WRITE_RESP: begin
                    if (bready) begin
                        state <= IDLE;                // held until B handshake
                    end
                end
                READ_RAM: begin
                    state <= READ_RESP;               // rdata captured on this edge
                end
                READ_RESP: begin
                    if (rready) begin
                        state <= IDLE;                // held until R handshake
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ##############################
    // read data capture
    // ##############################
    // stays put through READ_RESP so rdata is stable under back-pressure
    always_ff @(posedge clk) begin
        if (state == READ_RAM) begin
            rdata_q <= (rresp_q == SLVERR) ? '0 : ram.rdata;   // errors read as zero
        end
    end

endmodule

`default_nettype wire

// ==== design/bram.sv ====
// synchronous single-port word RAM with byte write mask, instanced behind the AXI controller
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module bram #(
    parameter int WIDTH = `MEM_DEPTH_BITS    // word address bits
) (
    input  wire   clk,
    ram_port_if.ram ram
);

    localparam int DEPTH = 1 << WIDTH;

    logic [`MEM_DATA_W-1:0] mem [0:DEPTH-1];   // word storage

    // ##############################
    // simulation start state
    // ##############################
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;                        // start from a clean scratchpad
        end
    end

    // ##############################
    // write lanes and read port
    // ##############################
    always @(posedge clk) begin
        if (ram.wr) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (ram.wmask[b]) begin
                    mem[ram.addr][b*8 +: 8] <= ram.wdata[b*8 +: 8];   // one byte lane
                end
            end
        end
        // nonblocking, so a same-cycle write shows up only on the next read
        ram.rdata <= mem[ram.addr];
    end

endmodule

`default_nettype wire

// ==== common/ram_port_if.sv ====
// single-port RAM access bundle between the AXI controller and the block RAM
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

interface ram_port_if #(
    parameter int AW = `MEM_DEPTH_BITS     // word address bits
);

    logic                    wr;       // write enable, one cycle per write
    logic [AW-1:0]           addr;     // word address, shared by read and write
    logic [`MEM_DATA_W-1:0]  wdata;    // write data
    logic [`MEM_STRB_W-1:0]  wmask;    // byte lanes to update
    logic [`MEM_DATA_W-1:0]  rdata;    // registered read data, one cycle late

    // controller side drives the access
    modport ctrl (
        output wr, addr, wdata, wmask,
        input  rdata
    );

    // RAM side answers with read data
    modport ram (
        input  wr, addr, wdata, wmask,
        output rdata
    );

endinterface

`default_nettype wire

// ==== common/mem_pkg.sv ====
// shared types for the scratchpad: AXI response codes and controller FSM states
`default_nettype none

package mem_pkg;

    // ##############################
    // axi response codes
    // ##############################
    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,    // normal access
        SLVERR = 2'b10     // address beyond the RAM depth
    } axi_resp_t;

    // ##############################
    // controller FSM
    // ##############################
    typedef enum logic [1:0] {
        IDLE       = 2'd0,  // waiting for a full write or a read
        WRITE_RESP = 2'd1,  // bvalid up, waiting for bready
        READ_RAM   = 2'd2,  // RAM output settling, captured at end of cycle
        READ_RESP  = 2'd3   // rvalid up, waiting for rready
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/mem_defs.svh ====
// bus and RAM sizing macros for the scratchpad, included by every file that needs a width
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ##############################
// axi4-lite bus widths
// ##############################
`define MEM_ADDR_W      32      // byte address width on the bus
`define MEM_DATA_W      32      // data width, one RAM word
`define MEM_STRB_W      4       // write strobe width, also the RAM byte mask

// ##############################
// RAM geometry
// ##############################
// word address bits; 10 bits gives 1024 words, i.e. 4 KiB
`define MEM_DEPTH_BITS  10

`endif
